// ==== Bender.yml ====
package:
  name: spi_flash_reader

sources:
  - files:
      - design/spi_flash_pkg.sv
      - design/flash_req_port.sv
      - design/spi_read_engine.sv
      - design/flash_rsp_port.sv
      - design/spi_flash_reader.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/spi_flash_model.sv
      - verif/tb_spi_flash_reader.sv

// ==== design/flash_req_port.sv ====
// flash request port holding one read address until the engine takes it

`timescale 1ns/1ps

module flash_req_port (
   input  logic                             clk,
   input  logic                             rst_n,
   // client side
   input  logic                             req_valid,
   input  logic [spi_flash_pkg::addr_w-1:0] req_addr,
   output logic                             req_ready,
   // engine side
   output logic                             cmd_valid,
   output logic [spi_flash_pkg::addr_w-1:0] cmd_addr,
   input  logic                             cmd_ready
);

   logic req_fire;                              // client transfer this cycle
   logic cmd_fire;                              // engine takes the entry this cycle

   assign req_fire = req_valid && req_ready;
   assign cmd_fire = cmd_valid && cmd_ready;

   // free when empty or when the entry leaves in this same cycle
   assign req_ready = !cmd_valid || cmd_ready;

   // entry occupancy
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cmd_valid <= 1'b0;                     // empty after reset
      end else begin
         if (req_fire) begin
            cmd_valid <= 1'b1;                  // new entry may replace a leaving one
         end else if (cmd_fire) begin
            cmd_valid <= 1'b0;                  // taken with nothing behind it
         end
      end
   end

   // address payload
   always_ff @(posedge clk) begin
      if (req_fire) begin
         cmd_addr <= req_addr;                  // captured on the client handshake
      end
   end

endmodule

// ==== design/flash_rsp_port.sv ====
// flash response port: packs four received bytes little endian and holds the word until taken

`timescale 1ns/1ps

module flash_rsp_port (
   input  logic                             clk,
   input  logic                             rst_n,
   // bytes from the engine
   input  logic                             byte_valid,
   input  logic [7:0]                       byte_data,
   output logic                             word_free,
   // client side
   output logic                             rsp_valid,
   output logic [spi_flash_pkg::word_w-1:0] rsp_data,
   input  logic                             rsp_ready
);

   logic [spi_flash_pkg::lane_w-1:0] lane;      // lane for the next byte
   logic                             rsp_fire;  // client takes the word
   logic                             word_end;  // closing byte of the word

   assign rsp_fire = rsp_valid && rsp_ready;
   assign word_end = byte_valid && (lane == spi_flash_pkg::last_lane);

   // engine may start only while no finished word is waiting
   assign word_free = !rsp_valid;

   // lane counter and response flag
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lane      <= '0;
         rsp_valid <= 1'b0;
      end else begin
         if (byte_valid) begin
            lane <= lane + 1'b1;                // wraps back to lane 0 after the word
         end
         if (word_end) begin
            rsp_valid <= 1'b1;                  // word complete
         end else if (rsp_fire) begin
            rsp_valid <= 1'b0;
         end
      end
   end

   // byte lanes, first byte in the low lane
   always_ff @(posedge clk) begin
      if (byte_valid) begin
         rsp_data[lane*8 +: 8] <= byte_data;
      end
   end

   // a stalled response stays put
   a_rsp_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data)
   ) else $error("rsp_data changed under back-pressure");

endmodule

// ==== design/spi_flash_pkg.sv ====
// spi flash reader package: read command encoding, widths and the shifted command word

package spi_flash_pkg;

   // bus widths
   localparam int addr_w = 24;                   // flash byte address
   localparam int word_w = 32;                   // response word
   localparam int op_w   = 8;                    // command opcode

   // transfer shape
   localparam int bytes_per_word = 4;            // data bytes clocked in per read
   localparam int cmd_bits       = op_w + addr_w; // opcode then address, msb first

   // byte lane index, used for counting received bytes
   localparam int lane_w = $clog2(bytes_per_word);
   localparam logic [lane_w-1:0] last_lane = lane_w'(bytes_per_word - 1);

   // standard serial read, no dummy cycles
   localparam logic [op_w-1:0] read_opcode = 8'h03;

   // the command shift register
   // loaded through the field view, shifted out through the raw view
   typedef union packed {
      struct packed {
         logic [op_w-1:0]   opcode;             // goes out first
         logic [addr_w-1:0] addr;               // msb first after the opcode
      } cmd;
      logic [cmd_bits-1:0] raw;                 // bit cmd_bits-1 drives mosi
   } flash_cmd_u;

endpackage

// ==== design/spi_flash_reader.sv ====
// spi flash reader top: request port, spi read engine and response port wired together

`timescale 1ns/1ps

module spi_flash_reader (
   input  logic                             clk,
   input  logic                             rst_n,
   // read requests
   input  logic                             req_valid,
   input  logic [spi_flash_pkg::addr_w-1:0] req_addr,
   output logic                             req_ready,
   // read data
   output logic                             rsp_valid,
   output logic [spi_flash_pkg::word_w-1:0] rsp_data,
   input  logic                             rsp_ready,
   // flash pins
   output logic                             spi_sck,
   output logic                             spi_cs_n,
   output logic                             spi_mosi,
   input  logic                             spi_miso
);

   logic                             cmd_valid;  // queued read address
   logic [spi_flash_pkg::addr_w-1:0] cmd_addr;
   logic                             cmd_ready;
   logic                             word_free;  // response side can take a word
   logic                             byte_valid; // received byte pulse
   logic [7:0]                       byte_data;

   flash_req_port u_req_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .req_ready (req_ready),
      .cmd_valid (cmd_valid),
      .cmd_addr  (cmd_addr),
      .cmd_ready (cmd_ready)
   );

   spi_read_engine u_engine (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd_addr   (cmd_addr),
      .cmd_ready  (cmd_ready),
      .word_free  (word_free),
      .byte_valid (byte_valid),
      .byte_data  (byte_data),
      .spi_sck    (spi_sck),
      .spi_cs_n   (spi_cs_n),
      .spi_mosi   (spi_mosi),
      .spi_miso   (spi_miso)
   );

   flash_rsp_port u_rsp_port (
      .clk        (clk),
      .rst_n      (rst_n),
      .byte_valid (byte_valid),
      .byte_data  (byte_data),
      .word_free  (word_free),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data),
      .rsp_ready  (rsp_ready)
   );

endmodule

// ==== design/spi_read_engine.sv ====
// spi read engine: drives cs_n/sck at clk/2, shifts out opcode and address, shifts in data bytes

`timescale 1ns/1ps

module spi_read_engine (
   input  logic                             clk,
   input  logic                             rst_n,
   // command from the request port
   input  logic                             cmd_valid,
   input  logic [spi_flash_pkg::addr_w-1:0] cmd_addr,
   output logic                             cmd_ready,
   // response port has room for a whole word
   input  logic                             word_free,
   // received bytes, one cycle pulses
   output logic                             byte_valid,
   output logic [7:0]                       byte_data,
   // flash pins
   output logic                             spi_sck,
   output logic                             spi_cs_n,
   output logic                             spi_mosi,
   input  logic                             spi_miso
);

   spi_flash_pkg::flash_cmd_u cmd_sh;           // command shift register

   logic                             busy;      // cs_n low, sck running
   logic [5:0]                       snd_cnt;   // command bits left to send
   logic [2:0]                       rcv_cnt;   // bit index in the current data byte
   logic [spi_flash_pkg::lane_w-1:0] byte_cnt;  // data bytes done
   logic                             rcv_done;  // last data bit sampled
   logic [6:0]                       rcv_sh;    // data bits so far, msb first

   logic sending;                               // command phase
   logic receiving;                             // data phase
   logic accept;                                // new command this cycle
   logic shift_en;                              // sck falling, next command bit
   logic sample_en;                             // sck rising, take miso
   logic last_bit;                              // closing bit of the closing byte

   assign sending   = (snd_cnt != 6'd0);
   assign receiving = busy && !sending && !rcv_done;

   // only start when idle and the whole word can be stored
   assign cmd_ready = !busy && word_free;
   assign accept    = cmd_valid && cmd_ready;

   // low phase ends in a rising edge, high phase in a falling edge
   assign shift_en  = busy && spi_sck && sending;
   assign sample_en = !spi_sck && receiving;
   assign last_bit  = (rcv_cnt == 3'd7) && (byte_cnt == spi_flash_pkg::last_lane);

   assign spi_mosi = sending && cmd_sh.raw[spi_flash_pkg::cmd_bits-1]; // low during data phase

   // sequencing and pins
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy       <= 1'b0;
         spi_cs_n   <= 1'b1;                    // deselected
         spi_sck    <= 1'b0;                    // mode 0 idles low
         snd_cnt    <= 6'd0;
         rcv_cnt    <= 3'd0;
         byte_cnt   <= '0;
         rcv_done   <= 1'b0;
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= 1'b0;                    // pulse by default
         if (accept) begin
            busy     <= 1'b1;
            spi_cs_n <= 1'b0;                   // select, first bit already on mosi
            spi_sck  <= 1'b0;
            snd_cnt  <= 6'(spi_flash_pkg::cmd_bits);
            rcv_cnt  <= 3'd0;
            byte_cnt <= '0;
            rcv_done <= 1'b0;
         end else if (busy) begin
            spi_sck <= !spi_sck;                // clk/2, only while selected
            if (shift_en) begin
               snd_cnt <= snd_cnt - 6'd1;       // one command bit gone
            end
            if (sample_en) begin
               rcv_cnt <= rcv_cnt + 3'd1;       // wraps every byte
               if (rcv_cnt == 3'd7) begin
                  byte_valid <= 1'b1;           // whole byte in
                  byte_cnt   <= byte_cnt + 1'b1;
               end
               if (last_bit) begin
                  rcv_done <= 1'b1;             // finish on the coming falling edge
               end
            end
            if (spi_sck && rcv_done) begin
               busy     <= 1'b0;
               spi_cs_n <= 1'b1;                // deselect with sck back low
            end
         end
      end
   end

   // command and data shifters
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_sh.cmd.opcode <= spi_flash_pkg::read_opcode;
         cmd_sh.cmd.addr   <= cmd_addr;
      end else if (shift_en) begin
         cmd_sh.raw <= {cmd_sh.raw[spi_flash_pkg::cmd_bits-2:0], 1'b0}; // msb first
      end
      if (sample_en) begin
         rcv_sh <= {rcv_sh[5:0], spi_miso};
         if (rcv_cnt == 3'd7) begin
            byte_data <= {rcv_sh, spi_miso};    // flash sends msb first
         end
      end
   end

   // no clock edges reach a deselected flash
   a_sck_idle: assert property (
      @(posedge clk) disable iff (!rst_n)
      spi_cs_n |-> !spi_sck
   ) else $error("sck high while cs_n is high");

   // bytes only come out of the data phase of a selected transfer
   a_byte_framing: assert property (
      @(posedge clk) disable iff (!rst_n)
      byte_valid |-> !spi_cs_n && !sending
   ) else $error("byte_valid outside the data phase");

endmodule

// ==== list.f ====
design/spi_flash_pkg.sv
design/flash_req_port.sv
design/spi_read_engine.sv
design/flash_rsp_port.sv
design/spi_flash_reader.sv
verif/clk_gen.sv
verif/spi_flash_model.sv
verif/tb_spi_flash_reader.sv

// ==== verif/clk_gen.sv ====
// testbench clock source: free running clock with a 4 ns period

`timescale 1ns/1ps

module clk_gen (
   output logic clk
);

   localparam int half_period = 2;              // ns, gives a 4 ns period

   initial begin
      clk = 1'b0;                               // first rising edge at 2 ns
      forever #half_period clk = ~clk;
   end

endmodule

// ==== verif/spi_flash_model.sv ====
// spi flash model: mode 0 serial read target that answers from an address rule

`timescale 1ns/1ps

module spi_flash_model (
   input  logic                           spi_sck,
   input  logic                           spi_cs_n,
   input  logic                           spi_mosi,
   output logic                           spi_miso,
   output logic [spi_flash_pkg::op_w-1:0] last_opcode,  // opcode of the latest frame
   output int                             frame_errors, // frames that ended mid byte
   output int                             frames        // chip select low periods
);

   int unsigned                          bit_cnt;       // sck rising edges in this frame
   int unsigned                          data_idx;      // data bit being returned
   logic [spi_flash_pkg::cmd_bits-1:0]   cmd_sh;        // opcode and address as received
   logic [spi_flash_pkg::addr_w-1:0]     base_addr;     // first address of the read
   logic [7:0]                           data_byte;

   // stored content: low address byte ^ middle address byte ^ a5
   function automatic logic [7:0] stored_byte(input logic [spi_flash_pkg::addr_w-1:0] a);
      return a[7:0] ^ a[15:8] ^ 8'hA5;
   endfunction

   initial begin
      spi_miso     = 1'b0;
      last_opcode  = '0;
      frame_errors = 0;
      frames       = 0;
      bit_cnt      = 0;
      cmd_sh       = '0;
      base_addr    = '0;
   end

   // new frame
   always @(negedge spi_cs_n) begin
      bit_cnt = 0;
      frames++;
   end

   // frame closed, must end on a byte boundary
   always @(posedge spi_cs_n) begin
      if (bit_cnt % 8 != 0) begin
         frame_errors++;
         $display("flash model: frame closed after %0d bits, not a whole byte", bit_cnt);
      end
   end

   // mode 0, mosi taken on rising sck
   always @(posedge spi_sck) begin
      if (!spi_cs_n) begin
         if (bit_cnt < spi_flash_pkg::cmd_bits) begin
            cmd_sh = {cmd_sh[spi_flash_pkg::cmd_bits-2:0], spi_mosi}; // msb first
         end
         bit_cnt++;
         if (bit_cnt == spi_flash_pkg::op_w) begin
            last_opcode = cmd_sh[spi_flash_pkg::op_w-1:0];
         end
         if (bit_cnt == spi_flash_pkg::cmd_bits) begin
            base_addr = cmd_sh[spi_flash_pkg::addr_w-1:0];
         end
      end
   end

   // miso updated after falling sck, once the command is in
   always @(negedge spi_sck) begin
      if (!spi_cs_n && bit_cnt >= spi_flash_pkg::cmd_bits) begin
         data_idx  = bit_cnt - spi_flash_pkg::cmd_bits;
         data_byte = stored_byte(base_addr + spi_flash_pkg::addr_w'(data_idx / 8)); // next address
         spi_miso  = data_byte[7 - (data_idx % 8)];                               // msb first
      end
   end

endmodule

// ==== verif/tb_spi_flash_reader.sv ====
// spi flash reader testbench: directed reads against a flash model, checked with the address rule

`timescale 1ns/1ps

module tb_spi_flash_reader;

   localparam int reset_cycles = 8;
   localparam int test_count   = 12;
   localparam int test_cycles  = 300;                               // budget per test
   localparam int cycle_limit  = test_count * test_cycles + reset_cycles;
   localparam int wait_limit   = 400;                               // per handshake
   localparam int stall_cycles = 200;

   logic                                 clk;
   logic                                 rst_n;
   logic                                 req_valid;
   logic [spi_flash_pkg::addr_w-1:0]     req_addr;
   logic                                 req_ready;
   logic                                 rsp_valid;
   logic [spi_flash_pkg::word_w-1:0]     rsp_data;
   logic                                 rsp_ready;
   logic                                 spi_sck;
   logic                                 spi_cs_n;
   logic                                 spi_mosi;
   logic                                 spi_miso;
   logic [spi_flash_pkg::op_w-1:0]       last_opcode;
   int                                   frame_errors;
   int                                   frames;

   int    cycles = 0;                                               // run length so far
   int    test_errors;                                              // errors in the open test
   int    passed = 0;
   int    failed = 0;
   int    reads = 0;                                                // requests sent
   string test_name;

   clk_gen u_clk (.clk(clk));

   spi_flash_reader i_spi_flash_reader (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .req_ready (req_ready),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data),
      .rsp_ready (rsp_ready),
      .spi_sck   (spi_sck),
      .spi_cs_n  (spi_cs_n),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso)
   );

   spi_flash_model u_flash (
      .spi_sck      (spi_sck),
      .spi_cs_n     (spi_cs_n),
      .spi_mosi     (spi_mosi),
      .spi_miso     (spi_miso),
      .last_opcode  (last_opcode),
      .frame_errors (frame_errors),
      .frames       (frames)
   );

   // hard stop for a hung handshake
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // flash content: low byte ^ middle byte ^ a5
   function automatic logic [7:0] rule_byte(input logic [spi_flash_pkg::addr_w-1:0] a);
      return a[7:0] ^ a[15:8] ^ 8'hA5;
   endfunction

   // bytes a..a+3, first one in the low lane
   function automatic logic [spi_flash_pkg::word_w-1:0] expected_word(
      input logic [spi_flash_pkg::addr_w-1:0] a);
      logic [spi_flash_pkg::word_w-1:0] w;
      for (int i = 0; i < spi_flash_pkg::bytes_per_word; i++) begin
         w[i*8 +: 8] = rule_byte(a + spi_flash_pkg::addr_w'(i)); // wraps at 24 bits
      end
      return w;
   endfunction

   task automatic open_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic close_test();
      if (test_errors == 0) begin
         passed++;
         $display("test %s: ok", test_name);
      end else begin
         failed++;
         $display("test %s: %0d errors", test_name, test_errors);
      end
   endtask

   task automatic note_failure(input string what);
      test_errors++;
      $display("ERROR in %s: %s", test_name, what);
   endtask

   task automatic compare_word(input logic [spi_flash_pkg::word_w-1:0] expected,
                               input logic [spi_flash_pkg::word_w-1:0] actual);
      if (actual !== expected) begin
         test_errors++;
         $display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
      end
   endtask

   task automatic opcode_matches(input logic [spi_flash_pkg::op_w-1:0] expected,
                                 input logic [spi_flash_pkg::op_w-1:0] actual);
      if (actual !== expected) begin
         test_errors++;
         $display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
      end
   endtask

   // called on a falling edge, returns on a falling edge
   task automatic send_request(input logic [spi_flash_pkg::addr_w-1:0] addr);
      int waited;
      waited    = 0;
      req_valid = 1'b1;
      req_addr  = addr;
      while (!req_ready && waited < wait_limit) begin
         @(negedge clk);
         waited++;
      end
      if (!req_ready) begin
         note_failure("request was not accepted in time");
      end
      @(negedge clk);                                               // transfer on the edge before
      req_valid = 1'b0;
      reads++;
   endtask

   task automatic wait_response();
      int waited;
      waited = 0;
      while (!rsp_valid && waited < wait_limit) begin
         @(negedge clk);
         waited++;
      end
   endtask

   task automatic take_response(output logic [spi_flash_pkg::word_w-1:0] data);
      wait_response();
      if (!rsp_valid) begin
         note_failure("no response arrived in time");
         data = 'x;
      end else begin
         if (!spi_cs_n) begin
            note_failure("chip select still low while a word is offered");
         end
         data      = rsp_data;
         rsp_ready = 1'b1;                                          // one cycle handshake
         @(negedge clk);
         rsp_ready = 1'b0;
      end
   endtask

   task automatic read_and_check(input logic [spi_flash_pkg::addr_w-1:0] addr);
      logic [spi_flash_pkg::word_w-1:0] data;
      send_request(addr);
      take_response(data);
      compare_word(expected_word(addr), data);
   endtask

   task automatic reset_values();
      open_test("reset_values");
      if (spi_cs_n !== 1'b1) note_failure("spi_cs_n not high after reset");
      if (spi_sck !== 1'b0) note_failure("spi_sck not low after reset");
      if (rsp_valid !== 1'b0) note_failure("rsp_valid not low after reset");
      if (req_ready !== 1'b1) note_failure("req_ready not high after reset");
      close_test();
   endtask

   task automatic single_read(input string name, input logic [spi_flash_pkg::addr_w-1:0] addr);
      open_test(name);
      read_and_check(addr);
      opcode_matches(spi_flash_pkg::read_opcode, last_opcode);
      close_test();
   endtask

   task automatic back_to_back();
      logic [spi_flash_pkg::word_w-1:0] first;
      logic [spi_flash_pkg::word_w-1:0] second;
      open_test("back_to_back");
      send_request(24'h001234);                                     // second queues in the port
      send_request(24'h7F0080);
      take_response(first);
      take_response(second);
      compare_word(expected_word(24'h001234), first);
      compare_word(expected_word(24'h7F0080), second);
      close_test();
   endtask

   task automatic stalled_response();
      logic [spi_flash_pkg::word_w-1:0] data;
      open_test("stalled_response");
      send_request(24'h00A0F0);
      send_request(24'h3C0102);
      wait_response();
      repeat (stall_cycles) begin
         @(negedge clk);
         if (!rsp_valid) note_failure("rsp_valid dropped while rsp_ready was low");
         if (req_ready) note_failure("req_ready high with a full request entry");
         if (!spi_cs_n) note_failure("engine started while a word was waiting");
         compare_word(expected_word(24'h00A0F0), rsp_data);
      end
      take_response(data);
      compare_word(expected_word(24'h00A0F0), data);
      take_response(data);                                          // queued one not lost
      compare_word(expected_word(24'h3C0102), data);
      close_test();
   endtask

   task automatic random_reads();
      logic [31:0] r;
      open_test("random_reads");
      repeat (8) begin
         r = $urandom();
         read_and_check(r[spi_flash_pkg::addr_w-1:0]);              // masked to addr_w
      end
      close_test();
   endtask

   task automatic framing_and_cs();
      open_test("framing_and_cs");
      if (frame_errors != 0) note_failure("flash model saw frames ending mid byte");
      if (frames != reads) note_failure("chip select frames do not match the read count");
      if (spi_cs_n !== 1'b1) note_failure("spi_cs_n not high when idle");
      close_test();
   endtask

   initial begin
      void'($urandom(72));
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req_addr  = '0;
      rsp_ready = 1'b0;
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      reset_values();
      single_read("read_zero", 24'h000000);
      single_read("read_boundary", 24'h12FFFE);                     // crosses into 0x130000
      back_to_back();
      stalled_response();
      random_reads();
      framing_and_cs();
      $display("tests passed %0d failed %0d", passed, failed);
      if (failed == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
